// ==== periph_core.f ====
+incdir+.
periph_bus_pkg.sv
periph_io_pkg.sv
wb_decode.sv
gpio_port.sv
pb_debounce.sv
button_events.sv
bot_link.sv
periph_core.sv
tb_periph_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the peripheral testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f periph_core.f --top-module tb_periph_core \
   && ./obj_dir/Vtb_periph_core | tee /dev/stderr | grep -F "sim passed" > /dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== tb_periph_core.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

module tb_periph_core;

   localparam int HALF_PERIOD = 4;
   localparam int ACK_LIMIT   = 16;
   localparam int DB_WAIT     = `DEBOUNCE_CYCLES + 4;
   // the watchdog is sized from the bus accesses and debounce waits in the sequence below
   localparam int N_ACCESS    = 46;
   localparam int N_DB_TESTS  = 7;
   localparam int WATCHDOG_CYCLES = 10 + N_ACCESS * 10 + N_DB_TESTS * 4 * DB_WAIT + 200;

   logic                      clk = 1'b0;
   logic                      rst_n;
   periph_bus_pkg::adr_t      wb_adr;
   periph_bus_pkg::dat_t      wb_dat;
   logic                      wb_we;
   logic                      wb_cyc;
   logic                      wb_stb;
   periph_bus_pkg::dat_t      wb_rdt;
   logic                      wb_ack;
   logic [`GPIO_W-1:0]        gpio_in;
   logic [`GPIO_W-1:0]        gpio_out;
   logic [`GPIO_W-1:0]        gpio_oe;
   periph_io_pkg::btn_t       btn;
   periph_io_pkg::sw_t        sw;
   periph_io_pkg::bot_ctrl_t  bot_ctrl;
   periph_io_pkg::bot_info_t  bot_info;
   logic                      bot_updt;
   logic                      bot_int_ack;
   logic                      bot_config;
   logic                      btn_irq;
   logic                      bot_irq;
   int                        ack_pulses = 0;

   always #HALF_PERIOD clk = ~clk;

   periph_core i_periph_core (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_wb_adr        (wb_adr),
      .i_wb_dat        (wb_dat),
      .i_wb_we         (wb_we),
      .i_wb_cyc        (wb_cyc),
      .i_wb_stb        (wb_stb),
      .o_wb_rdt        (wb_rdt),
      .o_wb_ack        (wb_ack),
      .i_gpio_in       (gpio_in),
      .o_gpio_out      (gpio_out),
      .o_gpio_oe       (gpio_oe),
      .i_btn           (btn),
      .i_sw            (sw),
      .o_bot_ctrl      (bot_ctrl),
      .i_bot_info      (bot_info),
      .i_bot_updt_sync (bot_updt),
      .o_bot_int_ack   (bot_int_ack),
      .o_bot_config    (bot_config),
      .o_btn_irq       (btn_irq),
      .o_bot_irq       (bot_irq)
   );

   // ********************
   // reporting and bus helpers
   // ********************

   task automatic report_failure(input string why);
      $display("sim failed");
      $display("%s", why);
      $fatal(1, "run aborted");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      report_failure($sformatf("ERR %s expected %h got %h", name, exp, got));
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      assert (got === exp) else report_mismatch(name, exp, got);
   endtask

   // byte address of a word register inside one block
   function automatic periph_bus_pkg::adr_t reg_adr(input logic [3:0] sel,
                                                   input logic [3:0] ofs);
      periph_bus_pkg::adr_t a;
      a = '0;
      a[`SEL_MSB:`SEL_LSB] = sel;
      a[`OFS_MSB:`OFS_LSB] = ofs;
      return a;
   endfunction

   // one wishbone classic access with ack and read data looked at on the falling edge
   task automatic bus_access(input periph_bus_pkg::adr_t adr, input logic we,
                             input periph_bus_pkg::dat_t wdat,
                             output periph_bus_pkg::dat_t rdat);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_adr <= adr;
      wb_dat <= wdat;
      wb_we  <= we;
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      @(negedge clk);
      while (!wb_ack) begin
         waited++;
         if (waited > ACK_LIMIT) begin
            report_failure($sformatf("no ack for the access to address %h", adr));
         end
         @(negedge clk);
      end
      rdat = wb_rdt;
      // strobe drops on the edge that ends the ack cycle
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge clk);
   endtask

   task automatic bus_write(input periph_bus_pkg::adr_t adr, input periph_bus_pkg::dat_t dat);
      periph_bus_pkg::dat_t unused;
      bus_access(adr, 1'b1, dat, unused);
   endtask

   task automatic read_expect(input periph_bus_pkg::adr_t adr, input periph_bus_pkg::dat_t exp,
                              input string name);
      periph_bus_pkg::dat_t got;
      bus_access(adr, 1'b0, '0, got);
      check_value(name, exp, got);
   endtask

   // long enough for the synchronizer, the full stable count and the pending flop
   task automatic wait_debounce();
      repeat (DB_WAIT) @(posedge clk);
   endtask

   // ********************
   // protocol checks
   // ********************

   // every sampled request without ack is answered on the very next edge
   ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
      else report_mismatch("o_wb_ack", 32'h1, 32'h0);

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else report_mismatch("o_wb_ack", 32'h0, 32'h1);

   ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> (wb_cyc && wb_stb))
      else report_mismatch("o_wb_ack", 32'h0, 32'h1);

   int_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      bot_int_ack |=> !bot_int_ack)
      else report_mismatch("o_bot_int_ack", 32'h0, 32'h1);

   // count acknowledge pulses on the edge that ends each one
   always @(posedge clk) begin
      if (rst_n && bot_int_ack) begin
         ack_pulses++;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_failure("watchdog expired before the test sequence finished");
   end

   // ********************
   // test sequence
   // ********************

   initial begin
      periph_bus_pkg::dat_t d;
      periph_bus_pkg::dat_t out_v;
      periph_bus_pkg::dat_t info_a;
      periph_bus_pkg::dat_t info_b;
      periph_io_pkg::sw_t   sw_v;
      int                   ack_before;
      void'($urandom(32'h3ae3_8fb6));
      rst_n    <= 1'b0;
      wb_adr   <= '0;
      wb_dat   <= '0;
      wb_we    <= 1'b0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      gpio_in  <= '0;
      btn      <= '0;
      sw       <= '0;
      bot_info <= '0;
      bot_updt <= 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("o_wb_ack", 32'h0, 32'(wb_ack));
      check_value("o_gpio_out", 32'h0, gpio_out);
      check_value("o_gpio_oe", 32'h0, gpio_oe);
      check_value("o_bot_ctrl", 32'h0, 32'(bot_ctrl));
      check_value("o_bot_int_ack", 32'h0, 32'(bot_int_ack));
      check_value("o_btn_irq", 32'h0, 32'(btn_irq));
      check_value("o_bot_irq", 32'h0, 32'(bot_irq));

      for (int k = 0; k < 4; k++) begin
         out_v = $urandom;
         bus_write(reg_adr(`SEL_GPIO, `OFS_OUT), out_v);
         check_value("o_gpio_out", out_v, gpio_out);
         read_expect(reg_adr(`SEL_GPIO, `OFS_OUT), out_v, "o_wb_rdt gpio out");
         d = $urandom;
         bus_write(reg_adr(`SEL_GPIO, `OFS_OE), d);
         check_value("o_gpio_oe", d, gpio_oe);
         read_expect(reg_adr(`SEL_GPIO, `OFS_OE), d, "o_wb_rdt gpio oe");
      end

      // spare select values complete with zero read data and reach no block
      bus_write(reg_adr(4'd3, `OFS_OUT), $urandom);
      check_value("o_gpio_out", out_v, gpio_out);
      read_expect(reg_adr(4'd3, `OFS_OUT), 32'h0, "o_wb_rdt unmapped block 3");
      read_expect(reg_adr(4'd4, `OFS_OE), 32'h0, "o_wb_rdt unmapped block 4");
      read_expect(reg_adr(4'd15, `OFS_OUT), 32'h0, "o_wb_rdt unmapped block 15");

      // pad input needs two synchronizer cycles before it is readable
      for (int k = 0; k < 2; k++) begin
         d = $urandom;
         @(posedge clk);
         gpio_in <= d;
         repeat (3) @(posedge clk);
         read_expect(reg_adr(`SEL_GPIO, `OFS_IN), d, "o_wb_rdt gpio in");
      end
      read_expect(reg_adr(`SEL_GPIO, 4'd3), 32'h0, "o_wb_rdt gpio spare offset");

      // robot control byte takes the low 8 bits of the write
      d = $urandom;
      bus_write(reg_adr(`SEL_BOT, `OFS_CTRL), d);
      check_value("o_bot_ctrl", d & 32'hff, 32'(bot_ctrl));
      read_expect(reg_adr(`SEL_BOT, `OFS_CTRL), d & 32'hff, "o_wb_rdt bot ctrl");
      info_a = $urandom;
      info_b = $urandom;
      @(posedge clk);
      bot_info <= info_a;
      bot_updt <= 1'b1;
      for (int k = 0; k < 4 && !bot_irq; k++) begin
         @(negedge clk);
      end
      check_value("o_bot_irq", 32'h1, 32'(bot_irq));
      // the snapshot must ignore later changes of the status word
      @(posedge clk);
      bot_info <= info_b;
      bot_updt <= 1'b0;
      read_expect(reg_adr(`SEL_BOT, `OFS_INFO), info_a, "o_wb_rdt bot info");
      read_expect(reg_adr(`SEL_BOT, `OFS_STAT), 32'h1, "o_wb_rdt bot stat");
      ack_before = ack_pulses;
      bus_write(reg_adr(`SEL_BOT, `OFS_STAT), 32'h1);
      check_value("o_bot_irq", 32'h0, 32'(bot_irq));
      repeat (3) @(negedge clk);
      check_value("o_bot_int_ack pulse count", 32'(ack_before + 1), 32'(ack_pulses));
      read_expect(reg_adr(`SEL_BOT, `OFS_STAT), 32'h0, "o_wb_rdt bot stat");
      // a second update picks up the newer word
      @(posedge clk);
      bot_updt <= 1'b1;
      for (int k = 0; k < 4 && !bot_irq; k++) begin
         @(negedge clk);
      end
      check_value("o_bot_irq", 32'h1, 32'(bot_irq));
      read_expect(reg_adr(`SEL_BOT, `OFS_INFO), info_b, "o_wb_rdt bot info");
      @(posedge clk);
      bot_updt <= 1'b0;

      // a pulse shorter than the stable count leaves no trace
      @(posedge clk);
      btn[0] <= 1'b1;
      repeat (`DEBOUNCE_CYCLES - 2) @(posedge clk);
      btn[0] <= 1'b0;
      wait_debounce();
      read_expect(reg_adr(`SEL_BTN, `OFS_STATE), 32'h0, "o_wb_rdt btn state");
      read_expect(reg_adr(`SEL_BTN, `OFS_PEND), 32'h0, "o_wb_rdt btn pend");

      // bouncing press on button 0 with its interrupt enabled
      bus_write(reg_adr(`SEL_BTN, `OFS_IEN), 32'h1);
      @(posedge clk);
      btn[0] <= 1'b1;
      repeat (6) @(posedge clk);
      btn[0] <= 1'b0;
      repeat (2) @(posedge clk);
      btn[0] <= 1'b1;
      repeat (6) @(posedge clk);
      btn[0] <= 1'b0;
      @(posedge clk);
      btn[0] <= 1'b1;
      // each bounce restarted the count, so nothing has changed yet
      repeat (`DEBOUNCE_CYCLES - 4) @(posedge clk);
      @(negedge clk);
      check_value("o_btn_irq", 32'h0, 32'(btn_irq));
      wait_debounce();
      read_expect(reg_adr(`SEL_BTN, `OFS_STATE), 32'h1, "o_wb_rdt btn state");
      read_expect(reg_adr(`SEL_BTN, `OFS_PEND), 32'h1, "o_wb_rdt btn pend");
      check_value("o_btn_irq", 32'h1, 32'(btn_irq));
      bus_write(reg_adr(`SEL_BTN, `OFS_PEND), 32'h1);
      check_value("o_btn_irq", 32'h0, 32'(btn_irq));
      read_expect(reg_adr(`SEL_BTN, `OFS_PEND), 32'h0, "o_wb_rdt btn pend");
      @(posedge clk);
      btn[0] <= 1'b0;
      wait_debounce();

      // held press on button 1 pends but stays quiet until enabled
      @(posedge clk);
      btn[1] <= 1'b1;
      wait_debounce();
      read_expect(reg_adr(`SEL_BTN, `OFS_STATE), 32'h2, "o_wb_rdt btn state");
      read_expect(reg_adr(`SEL_BTN, `OFS_PEND), 32'h2, "o_wb_rdt btn pend");
      check_value("o_btn_irq", 32'h0, 32'(btn_irq));
      bus_write(reg_adr(`SEL_BTN, `OFS_IEN), 32'h3);
      check_value("o_btn_irq", 32'h1, 32'(btn_irq));
      bus_write(reg_adr(`SEL_BTN, `OFS_PEND), 32'h2);
      check_value("o_btn_irq", 32'h0, 32'(btn_irq));
      read_expect(reg_adr(`SEL_BTN, `OFS_PEND), 32'h0, "o_wb_rdt btn pend");
      // release is a falling edge and must not pend
      @(posedge clk);
      btn[1] <= 1'b0;
      wait_debounce();
      read_expect(reg_adr(`SEL_BTN, `OFS_STATE), 32'h0, "o_wb_rdt btn state");
      read_expect(reg_adr(`SEL_BTN, `OFS_PEND), 32'h0, "o_wb_rdt btn pend");

      // switches with the configuration switch first on and then off
      for (int k = 0; k < 2; k++) begin
         sw_v = 16'($urandom);
         sw_v[`BOT_CFG_SW] = (k == 0);
         @(posedge clk);
         sw <= sw_v;
         wait_debounce();
         read_expect(reg_adr(`SEL_BTN, `OFS_SW), 32'(sw_v), "o_wb_rdt switches");
         check_value("o_bot_config", 32'(sw_v[`BOT_CFG_SW]), 32'(bot_config));
      end

      $display("sim passed");
      $finish;
   end

endmodule

// ==== periph_core.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

// peripheral side of the board system
// one wishbone host port reaches gpio, buttons/switches and the robot link
module periph_core (
   input  logic                      clk,
   input  logic                      i_rst_n,
   // wishbone classic host port
   input  periph_bus_pkg::adr_t      i_wb_adr,
   input  periph_bus_pkg::dat_t      i_wb_dat,
   input  logic                      i_wb_we,
   input  logic                      i_wb_cyc,
   input  logic                      i_wb_stb,
   output periph_bus_pkg::dat_t      o_wb_rdt,
   output logic                      o_wb_ack,
   // gpio pads, split into input, output and enable
   input  logic [`GPIO_W-1:0]        i_gpio_in,
   output logic [`GPIO_W-1:0]        o_gpio_out,
   output logic [`GPIO_W-1:0]        o_gpio_oe,
   // raw buttons and switches
   input  periph_io_pkg::btn_t       i_btn,
   input  periph_io_pkg::sw_t        i_sw,
   // robot
   output periph_io_pkg::bot_ctrl_t  o_bot_ctrl,
   input  periph_io_pkg::bot_info_t  i_bot_info,
   input  logic                      i_bot_updt_sync,
   output logic                      o_bot_int_ack,
   output logic                      o_bot_config,
   // level interrupts
   output logic                      o_btn_irq,
   output logic                      o_bot_irq
);

   // ********************
   // decoder to block wiring
   // ********************

   logic                  stb_gpio;
   logic                  stb_btn;
   logic                  stb_bot;
   periph_bus_pkg::ofs_t  ofs;
   periph_bus_pkg::dat_t  rdt_gpio;
   periph_bus_pkg::dat_t  rdt_btn;
   periph_bus_pkg::dat_t  rdt_bot;
   logic                  ack_gpio;
   logic                  ack_btn;
   logic                  ack_bot;

   // debounced board inputs
   periph_io_pkg::btn_t   btn_db;
   periph_io_pkg::sw_t    sw_db;

   // the robot configuration line is a plain copy of one debounced switch
   assign o_bot_config = sw_db[`BOT_CFG_SW];

   wb_decode u_wb_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wb_adr   (i_wb_adr),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .o_stb_gpio (stb_gpio),
      .o_stb_btn  (stb_btn),
      .o_stb_bot  (stb_bot),
      .o_ofs      (ofs),
      .i_rdt_gpio (rdt_gpio),
      .i_rdt_btn  (rdt_btn),
      .i_rdt_bot  (rdt_bot),
      .i_ack_gpio (ack_gpio),
      .i_ack_btn  (ack_btn),
      .i_ack_bot  (ack_bot),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack)
   );

   // write data and write enable go to every block unchanged
   gpio_port #(
      .WIDTH (`GPIO_W)
   ) u_gpio_port (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_stb     (stb_gpio),
      .i_we      (i_wb_we),
      .i_ofs     (ofs),
      .i_dat     (i_wb_dat),
      .o_rdt     (rdt_gpio),
      .o_ack     (ack_gpio),
      .i_pad_in  (i_gpio_in),
      .o_pad_out (o_gpio_out),
      .o_pad_oe  (o_gpio_oe)
   );

   pb_debounce u_pb_debounce (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_btn   (i_btn),
      .i_sw    (i_sw),
      .o_btn   (btn_db),
      .o_sw    (sw_db)
   );

   button_events u_button_events (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_stb   (stb_btn),
      .i_we    (i_wb_we),
      .i_ofs   (ofs),
      .i_dat   (i_wb_dat),
      .o_rdt   (rdt_btn),
      .o_ack   (ack_btn),
      .i_btn   (btn_db),
      .i_sw    (sw_db),
      .o_irq   (o_btn_irq)
   );

   bot_link u_bot_link (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_stb           (stb_bot),
      .i_we            (i_wb_we),
      .i_ofs           (ofs),
      .i_dat           (i_wb_dat),
      .o_rdt           (rdt_bot),
      .o_ack           (ack_bot),
      .o_bot_ctrl      (o_bot_ctrl),
      .i_bot_info      (i_bot_info),
      .i_bot_updt_sync (i_bot_updt_sync),
      .o_int_ack       (o_bot_int_ack),
      .o_irq           (o_bot_irq)
   );

endmodule

// ==== bot_link.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

// robot link: control byte out, status word in, update interrupt
module bot_link (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_stb,
   input  logic                      i_we,
   input  periph_bus_pkg::ofs_t      i_ofs,
   input  periph_bus_pkg::dat_t      i_dat,
   output periph_bus_pkg::dat_t      o_rdt,
   output logic                      o_ack,
   output periph_io_pkg::bot_ctrl_t  o_bot_ctrl,
   input  periph_io_pkg::bot_info_t  i_bot_info,
   input  logic                      i_bot_updt_sync,
   output logic                      o_int_ack,
   output logic                      o_irq
);

   logic                     wr_en;
   logic                     clr_req;
   logic [2:0]               updt_q;
   logic                     updt_rise;
   periph_io_pkg::bot_info_t info_q;

   assign wr_en = i_stb & i_we & ~o_ack;

   // the clear write as the host presents it, bit 0 set at OFS_STAT
   assign clr_req = i_stb & i_we & (i_ofs == `OFS_STAT) & i_dat[0];

   // two flops to synchronize, the third one gives the edge
   assign updt_rise = updt_q[1] & ~updt_q[2];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ack      <= 1'b0;
         o_bot_ctrl <= '0;
         updt_q     <= '0;
         o_irq      <= 1'b0;
         o_int_ack  <= 1'b0;
      end else begin
         o_ack  <= i_stb & ~o_ack;
         updt_q <= {updt_q[1:0], i_bot_updt_sync};
         if (wr_en && i_ofs == `OFS_CTRL) begin
            o_bot_ctrl <= i_dat[7:0];
         end
         // pending flag, a fresh update beats a clear in the same cycle
         if (updt_rise) begin
            o_irq <= 1'b1;
         end else if (wr_en && clr_req) begin
            o_irq <= 1'b0;
         end
         // the host still holds the clear write during its ack cycle
         // so this pulse follows the ack by exactly one cycle
         o_int_ack <= o_ack & clr_req;
      end
   end

   // status snapshot, held until the next update edge
   always_ff @(posedge clk) begin
      if (updt_rise) begin
         info_q <= i_bot_info;
      end
   end

   always_comb begin
      o_rdt = '0;
      case (i_ofs)
         `OFS_CTRL: o_rdt[7:0] = o_bot_ctrl;
         `OFS_INFO: o_rdt      = info_q;
         `OFS_STAT: o_rdt[0]   = o_irq;
         default:   o_rdt      = '0;
      endcase
   end

endmodule

// ==== button_events.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

// register block for debounced buttons and switches
module button_events (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  periph_bus_pkg::ofs_t  i_ofs,
   input  periph_bus_pkg::dat_t  i_dat,
   output periph_bus_pkg::dat_t  o_rdt,
   output logic                  o_ack,
   input  periph_io_pkg::btn_t   i_btn,
   input  periph_io_pkg::sw_t    i_sw,
   output logic                  o_irq
);

   logic                wr_en;
   periph_io_pkg::btn_t btn_q;
   periph_io_pkg::btn_t rise;
   periph_io_pkg::btn_t clr;
   periph_io_pkg::btn_t pend;
   periph_io_pkg::btn_t ien;

   assign wr_en = i_stb & i_we & ~o_ack;

   // rising edges of the debounced buttons
   assign rise = i_btn & ~btn_q;

   // write one to clear, pending bits ignore zeros
   assign clr = (wr_en && i_ofs == `OFS_PEND) ? i_dat[`BTN_N-1:0] : '0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ack <= 1'b0;
         btn_q <= '0;
         pend  <= '0;
         ien   <= '0;
      end else begin
         o_ack <= i_stb & ~o_ack;
         btn_q <= i_btn;
         // a new edge wins over a clear in the same cycle so no press is lost
         pend  <= (pend & ~clr) | rise;
         if (wr_en && i_ofs == `OFS_IEN) begin
            ien <= i_dat[`BTN_N-1:0];
         end
      end
   end

   // level interrupt from any enabled pending bit
   assign o_irq = |(pend & ien);

   always_comb begin
      o_rdt = '0;
      case (i_ofs)
         `OFS_STATE: o_rdt[`BTN_N-1:0] = i_btn;
         `OFS_PEND:  o_rdt[`BTN_N-1:0] = pend;
         `OFS_IEN:   o_rdt[`BTN_N-1:0] = ien;
         `OFS_SW:    o_rdt[`SW_N-1:0]  = i_sw;
         default:    o_rdt = '0;
      endcase
   end

endmodule

// ==== pb_debounce.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

// debouncer for pushbuttons and slide switches
// buttons and switches share one vector so every input runs the same logic
module pb_debounce (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  periph_io_pkg::btn_t  i_btn,
   input  periph_io_pkg::sw_t   i_sw,
   output periph_io_pkg::btn_t  o_btn,
   output periph_io_pkg::sw_t   o_sw
);

   localparam int N     = `BTN_N + `SW_N;
   localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

   logic [N-1:0]             raw;
   logic [N-1:0]             sync1;
   logic [N-1:0]             sync2;
   logic [N-1:0]             db;
   periph_io_pkg::db_state_e state [N];
   logic [CNT_W-1:0]         cnt [N];

   // buttons in the low bits, switches above them
   assign raw = {i_sw, i_btn};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sync1 <= '0;
         sync2 <= '0;
         db    <= '0;
         for (int i = 0; i < N; i++) begin
            state[i] <= periph_io_pkg::DB_STABLE;
            cnt[i]   <= '0;
         end
      end else begin
         // bring the board pins into the clock domain first
         sync1 <= raw;
         sync2 <= sync1;
         for (int i = 0; i < N; i++) begin
            case (state[i])
               periph_io_pkg::DB_STABLE: begin
                  // first cycle of a difference counts as one
                  if (sync2[i] != db[i]) begin
                     state[i] <= periph_io_pkg::DB_COUNTING;
                     cnt[i]   <= CNT_W'(1);
                  end
               end
               default: begin
                  if (sync2[i] == db[i]) begin
                     // a bounce back to the old level starts over
                     state[i] <= periph_io_pkg::DB_STABLE;
                     cnt[i]   <= '0;
                  end else if (cnt[i] == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
                     // this is the last of the required differing cycles
                     db[i]    <= sync2[i];
                     state[i] <= periph_io_pkg::DB_STABLE;
                     cnt[i]   <= '0;
                  end else begin
                     cnt[i] <= cnt[i] + CNT_W'(1);
                  end
               end
            endcase
         end
      end
   end

   assign o_btn = db[`BTN_N-1:0];
   assign o_sw  = db[N-1:`BTN_N];

endmodule

// ==== gpio_port.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

// general purpose i/o register block
module gpio_port #(
   parameter int WIDTH = `GPIO_W
) (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  periph_bus_pkg::ofs_t  i_ofs,
   input  periph_bus_pkg::dat_t  i_dat,
   output periph_bus_pkg::dat_t  o_rdt,
   output logic                  o_ack,
   input  logic [WIDTH-1:0]      i_pad_in,
   output logic [WIDTH-1:0]      o_pad_out,
   output logic [WIDTH-1:0]      o_pad_oe
);

   logic             wr_en;
   logic [WIDTH-1:0] pad_meta;
   logic [WIDTH-1:0] pad_sync;

   // the write lands on the same edge that raises ack
   assign wr_en = i_stb & i_we & ~o_ack;

   // ********************
   // bus registers
   // ********************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ack     <= 1'b0;
         o_pad_out <= '0;
         o_pad_oe  <= '0;
      end else begin
         o_ack <= i_stb & ~o_ack;
         if (wr_en && i_ofs == `OFS_OUT) begin
            o_pad_out <= i_dat[WIDTH-1:0];
         end
         if (wr_en && i_ofs == `OFS_OE) begin
            o_pad_oe <= i_dat[WIDTH-1:0];
         end
      end
   end

   // two flop synchronizer for the pad inputs
   // pad_sync is what software sees at OFS_IN
   always_ff @(posedge clk) begin
      pad_meta <= i_pad_in;
      pad_sync <= pad_meta;
   end

   // read mux, zero-extended to the bus width and zero on unused offsets
   always_comb begin
      o_rdt = '0;
      case (i_ofs)
         `OFS_IN:  o_rdt[WIDTH-1:0] = pad_sync;
         `OFS_OUT: o_rdt[WIDTH-1:0] = o_pad_out;
         `OFS_OE:  o_rdt[WIDTH-1:0] = o_pad_oe;
         default:  o_rdt = '0;
      endcase
   end

endmodule

// ==== wb_decode.sv ====
`timescale 1ns/1ps
`include "periph_settings.svh"

// address decoder for the peripheral bus
module wb_decode (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  periph_bus_pkg::adr_t  i_wb_adr,
   input  logic                  i_wb_cyc,
   input  logic                  i_wb_stb,
   output logic                  o_stb_gpio,
   output logic                  o_stb_btn,
   output logic                  o_stb_bot,
   output periph_bus_pkg::ofs_t  o_ofs,
   input  periph_bus_pkg::dat_t  i_rdt_gpio,
   input  periph_bus_pkg::dat_t  i_rdt_btn,
   input  periph_bus_pkg::dat_t  i_rdt_bot,
   input  logic                  i_ack_gpio,
   input  logic                  i_ack_btn,
   input  logic                  i_ack_bot,
   output periph_bus_pkg::dat_t  o_wb_rdt,
   output logic                  o_wb_ack
);

   periph_bus_pkg::slave_e slv;
   logic                   req;
   logic                   ack_none;

   // a request is only live while both cycle and strobe are up
   assign req = i_wb_cyc & i_wb_stb;

   // select field to target, any spare value falls to SLV_NONE
   always_comb begin
      case (i_wb_adr[`SEL_MSB:`SEL_LSB])
         `SEL_GPIO: slv = periph_bus_pkg::SLV_GPIO;
         `SEL_BTN:  slv = periph_bus_pkg::SLV_BTN;
         `SEL_BOT:  slv = periph_bus_pkg::SLV_BOT;
         default:   slv = periph_bus_pkg::SLV_NONE;
      endcase
   end

   // only one block ever sees its strobe
   assign o_stb_gpio = req & (slv == periph_bus_pkg::SLV_GPIO);
   assign o_stb_btn  = req & (slv == periph_bus_pkg::SLV_BTN);
   assign o_stb_bot  = req & (slv == periph_bus_pkg::SLV_BOT);

   // word offset is handed to every block, range checks are left to nobody
   assign o_ofs = i_wb_adr[`OFS_MSB:`OFS_LSB];

   // unmapped accesses still complete, with the same single-cycle ack as a block
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_none <= 1'b0;
      end else begin
         ack_none <= req & (slv == periph_bus_pkg::SLV_NONE) & ~ack_none;
      end
   end

   // return path, steered by the same select field the host is still holding
   always_comb begin
      case (slv)
         periph_bus_pkg::SLV_GPIO: begin
            o_wb_rdt = i_rdt_gpio;
            o_wb_ack = i_ack_gpio;
         end
         periph_bus_pkg::SLV_BTN: begin
            o_wb_rdt = i_rdt_btn;
            o_wb_ack = i_ack_btn;
         end
         periph_bus_pkg::SLV_BOT: begin
            o_wb_rdt = i_rdt_bot;
            o_wb_ack = i_ack_bot;
         end
         default: begin
            o_wb_rdt = '0;
            o_wb_ack = ack_none;
         end
      endcase
   end

endmodule

// ==== periph_io_pkg.sv ====
`include "periph_settings.svh"

// types that describe the board side of the peripherals
package periph_io_pkg;

   // pushbuttons, up/down/left/right/center order follows the board pins
   typedef logic [`BTN_N-1:0] btn_t;

   // slide switches
   typedef logic [`SW_N-1:0] sw_t;

   // robot control byte
   typedef logic [7:0] bot_ctrl_t;

   // robot status word, sampled on the update strobe
   typedef logic [31:0] bot_info_t;

   // per-input debounce state
   // DB_COUNTING means the synchronized input differs from the debounced value
   typedef enum logic {
      DB_STABLE   = 1'b0,
      DB_COUNTING = 1'b1
   } db_state_e;

endpackage

// ==== periph_bus_pkg.sv ====
`include "periph_settings.svh"

// types that describe the host side of the peripheral bus
package periph_bus_pkg;

   // host byte address
   typedef logic [`ADR_W-1:0] adr_t;

   // one bus data word
   typedef logic [`DAT_W-1:0] dat_t;

   // word offset inside a block, taken from address bits 5:2
   typedef logic [`OFS_MSB-`OFS_LSB:0] ofs_t;

   // target picked by the address decoder
   // SLV_NONE covers every select value without a block behind it
   typedef enum logic [1:0] {
      SLV_GPIO = 2'd0,
      SLV_BTN  = 2'd1,
      SLV_BOT  = 2'd2,
      SLV_NONE = 2'd3
   } slave_e;

endpackage

// ==== periph_settings.svh ====
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// ********************
// host bus
// ********************

// byte address and data word as seen by the host
`define ADR_W 16
`define DAT_W 32

// address bits 11:8 pick the block, bits 5:2 pick the word inside it
`define SEL_LSB 8
`define SEL_MSB 11
`define OFS_LSB 2
`define OFS_MSB 5

// block numbers in the select field
`define SEL_GPIO 4'd0
`define SEL_BTN  4'd1
`define SEL_BOT  4'd2

// ********************
// board side
// ********************

`define GPIO_W 32
`define BTN_N  5
`define SW_N   16

// slide switch that doubles as the robot configuration line
`define BOT_CFG_SW 15

// consecutive stable cycles before a debounced input may change
`define DEBOUNCE_CYCLES 16

// ********************
// register offsets
// ********************

// gpio block
`define OFS_IN  4'd0
`define OFS_OUT 4'd1
`define OFS_OE  4'd2

// button and switch block
`define OFS_STATE 4'd0
`define OFS_PEND  4'd1
`define OFS_IEN   4'd2
`define OFS_SW    4'd3

// robot block
`define OFS_CTRL 4'd0
`define OFS_INFO 4'd1
`define OFS_STAT 4'd2

`endif
